//--- src/isa_pkg.sv
package isa_pkg;

	// ========================================================================
	// architectural widths
	// ========================================================================

	typedef logic [7:0] data_t;     // datapath word
	typedef logic [2:0] reg_addr_t; // register file index
	typedef logic [7:0] imm8_t;     // full i8 immediate
	typedef logic [2:0] imm3_t;     // i3 immediate, also the shift amount

	localparam int NUM_REGS = 8;

	// instruction word, msb first: rn | op8 | imm
	// op8 stays a plain vector so undefined codes can still be carried
	typedef struct packed {
		reg_addr_t   rn;  // source and destination register
		logic [3:0]  op8; // i8 opcode, or the i3 prefix
		imm8_t       imm; // immediate, or i3/i0 opcode bits
	} instr_t;

	// ========================================================================
	// opcode spaces
	// ========================================================================

	// even opcode -> immediate form, odd -> register form
	typedef enum logic [3:0] {
		op8_ori    = 4'd0,
		op8_orr    = 4'd1,
		op8_andi   = 4'd2,
		op8_andr   = 4'd3,
		op8_addi   = 4'd4,
		op8_addr   = 4'd5,
		op8_subi   = 4'd6,
		op8_subr   = 4'd7,
		op8_ldi    = 4'd8,
		op8_prefix = 4'd15 // escape into the i3 space
	} op8_e;

	// lives in imm[7:4]
	typedef enum logic [3:0] {
		op3_shlzi  = 4'd0,
		op3_shlzr  = 4'd1,
		op3_shloi  = 4'd2,
		op3_shlor  = 4'd3,
		op3_shrzi  = 4'd4,
		op3_shrzr  = 4'd5,
		op3_asri   = 4'd6,
		op3_asrr   = 4'd7,
		op3_out    = 4'd11,
		op3_prefix = 4'd15 // escape into the i0 space
	} op3_e;

	// lives in imm[3:0]
	typedef enum logic [3:0] {
		op0_not = 4'd0,
		op0_nop = 4'd15
	} op0_e;

	// all prefixes set, falls through to the i0 nop
	localparam instr_t INSTR_NOP = '{rn: 3'd0, op8: 4'hf, imm: 8'hff};

endpackage

//--- src/pipe_pkg.sv
package pipe_pkg;

	import isa_pkg::*;

	// operation shared by both lanes
	typedef enum logic [3:0] {
		alu_or,
		alu_and,
		alu_add,
		alu_sub,
		alu_shlz,   // left, zero fill
		alu_shlo,   // left, one fill
		alu_shrz,   // logical right
		alu_asr,    // arithmetic right
		alu_not,    // ~a, b ignored
		alu_pass_b  // load immediate
	} alu_op_e;

	// which lane's result gets committed
	typedef enum logic [0:0] {
		lane_reg = 1'b0, // b from the register file
		lane_imm = 1'b1  // b from the immediate
	} lane_e;

	localparam int NUM_LANES = 2;

	// stage 1 register contents
	typedef struct packed {
		alu_op_e   alu_op;
		lane_e     lane;
		reg_addr_t rd;     // write-back target
		logic      wr_reg; // commit to the register file
		logic      wr_out; // commit to the output port
		data_t     a;      // rn contents
		data_t     b_reg;  // operand register contents
		data_t     b_imm;  // immediate, already extended
	} decoded_t;

	localparam decoded_t DEC_NOP = '{
		alu_op: alu_or,
		lane:   lane_imm,
		rd:     3'd0,
		wr_reg: 1'b0,
		wr_out: 1'b0,
		a:      8'd0,
		b_reg:  8'd0,
		b_imm:  8'd0
	};

endpackage

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file import isa_pkg::*; (
	input  logic      clk,
	input  reg_addr_t i_rd_addr_a,  // rn
	input  reg_addr_t i_rd_addr_b,  // operand register
	output data_t     o_rd_data_a,
	output data_t     o_rd_data_b,
	input  logic      i_wr_en,
	input  reg_addr_t i_wr_addr,
	input  data_t     i_wr_data
);

	// eight general registers, contents undefined until written
	data_t regs [NUM_REGS];

	// reads are combinational
	// a write in this cycle shows up only after the edge, no bypass
	assign o_rd_data_a = regs[i_rd_addr_a];
	assign o_rd_data_b = regs[i_rd_addr_b];

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			regs[i_wr_addr] <= i_wr_data; // commit slot, E+3
	end

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  instr_t    i_instr,
	output reg_addr_t o_rd_addr_a,
	output reg_addr_t o_rd_addr_b,
	input  data_t     i_rd_data_a,
	input  data_t     i_rd_data_b,
	output decoded_t  o_dec
);

	logic [3:0] op3;      // i3 opcode field
	logic [3:0] op0;      // i0 opcode field
	imm8_t      imm8;
	imm3_t      imm3;
	logic       is_i8;
	logic       is_i3;
	logic       src_reg;  // odd opcode, b comes from a register
	alu_op_e    op_sel;
	logic       op_ok;    // opcode is one we implement
	logic       is_out;
	decoded_t   dec_next;

	// ========================================================================
	// field split and prefix decode
	// ========================================================================

	assign op3  = i_instr.imm[7:4];
	assign op0  = i_instr.imm[3:0];
	assign imm8 = i_instr.imm;
	assign imm3 = i_instr.imm[2:0];

	assign is_i8 = (i_instr.op8 != op8_prefix);
	assign is_i3 = !is_i8 && (op3 != op3_prefix); // anything left over is i0

	assign src_reg = is_i8 ? i_instr.op8[0] :
	                 is_i3 ? op3[0] : 1'b0;

	// register operands are read straight off the port
	assign o_rd_addr_a = i_instr.rn;
	assign o_rd_addr_b = imm3; // register form names its operand in imm[2:0]

	always_comb
	begin
		op_sel = alu_or;
		op_ok  = 1'b1;
		is_out = 1'b0;
		if (is_i8)
		begin
			case (i_instr.op8)
				op8_ori, op8_orr:   op_sel = alu_or;
				op8_andi, op8_andr: op_sel = alu_and;
				op8_addi, op8_addr: op_sel = alu_add;
				op8_subi, op8_subr: op_sel = alu_sub;
				op8_ldi:            op_sel = alu_pass_b;
				default:            op_ok = 1'b0; // unused i8 codes are nops
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				op3_shlzi, op3_shlzr: op_sel = alu_shlz;
				op3_shloi, op3_shlor: op_sel = alu_shlo;
				op3_shrzi, op3_shrzr: op_sel = alu_shrz;
				op3_asri, op3_asrr:   op_sel = alu_asr;
				op3_out:              is_out = 1'b1; // a | 0 passes rn through
				default:              op_ok = 1'b0;
			endcase
		end
		else
		begin
			case (op0)
				op0_not: op_sel = alu_not;
				op0_nop: op_ok = 1'b0;
				default: op_ok = 1'b0;
			endcase
		end
	end

	// ========================================================================
	// operand assembly and stage 1 register
	// ========================================================================

	always_comb
	begin
		dec_next.alu_op = op_sel;
		dec_next.lane   = (src_reg && !is_out) ? lane_reg : lane_imm; // out rides lane_imm
		dec_next.rd     = i_instr.rn;
		dec_next.wr_reg = op_ok && !is_out;
		dec_next.wr_out = op_ok && is_out;
		dec_next.a      = i_rd_data_a;
		dec_next.b_reg  = i_rd_data_b;
		// i3 immediates zero extended, out forces zero so the or is a copy
		dec_next.b_imm  = is_out ? 8'd0 : (is_i8 ? imm8 : data_t'(imm3));
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			o_dec <= DEC_NOP;
		else
			o_dec <= dec_next; // E+1
	end

endmodule

//--- src/alu_lane.sv
`timescale 1ns/1ps

module alu_lane import isa_pkg::*, pipe_pkg::*; (
	input  logic    clk,
	input  alu_op_e i_op,
	input  data_t   i_a,
	input  data_t   i_b,
	output data_t   o_y
);

	imm3_t sh;  // shift amount
	data_t y;   // next result

	assign sh = i_b[2:0]; // upper bits of b are ignored by the shifters

	// ========================================================================
	// operation select
	// ========================================================================

	always_comb
	begin
		case (i_op)
			alu_or:     y = i_a | i_b;
			alu_and:    y = i_a & i_b;
			alu_add:    y = i_a + i_b; // wraps mod 256
			alu_sub:    y = i_a - i_b;
			alu_shlz:   y = i_a << sh;
			// shift the complement in zeros, then flip back, so the
			// vacated low bits come out as ones
			alu_shlo:   y = ~((~i_a) << sh);
			alu_shrz:   y = i_a >> sh;
			alu_asr:    y = data_t'($signed(i_a) >>> sh); // sign bit copied down
			alu_not:    y = ~i_a;
			alu_pass_b: y = i_b;   // ldi
			default:    y = i_a;
		endcase
	end

	// result register, lands at E+2
	always_ff @(posedge clk)
	begin
		o_y <= y;
	end

endmodule

//--- src/commit_stage.sv
`timescale 1ns/1ps

module commit_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  decoded_t  i_dec,
	input  data_t     i_lane_y [NUM_LANES], // registered lane results
	output logic      o_wr_en,
	output reg_addr_t o_wr_addr,
	output data_t     o_wr_data,
	output data_t     o_out,
	output logic      o_out_strobe
);

	// control fields that follow the lanes by one stage
	typedef struct packed {
		lane_e     lane;
		reg_addr_t rd;
		logic      wr_reg;
		logic      wr_out;
	} commit_ctl_t;

	commit_ctl_t ctl;
	data_t       result; // selected lane

	always_ff @(posedge clk)
	begin
		if (reset)
			ctl <= '0;  // no write, no output
		else
			ctl <= '{lane: i_dec.lane, rd: i_dec.rd, wr_reg: i_dec.wr_reg, wr_out: i_dec.wr_out};
	end

	assign result = i_lane_y[ctl.lane];

	// write port, the register file samples it at E+3
	assign o_wr_en   = ctl.wr_reg;
	assign o_wr_addr = ctl.rd;
	assign o_wr_data = result;

	// output port, one cycle strobe after E+3
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_out        <= 8'd0;
			o_out_strobe <= 1'b0;
		end
		else
		begin
			o_out_strobe <= ctl.wr_out;
			if (ctl.wr_out)
				o_out <= result; // holds between outs
		end
	end

endmodule

//--- src/pat_core.sv
`timescale 1ns/1ps

module pat_core import isa_pkg::*, pipe_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  instr_t i_instr,      // one per clock, INSTR_NOP when idle
	output data_t  o_out,
	output logic   o_out_strobe
);

	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	data_t     rd_data_a;
	data_t     rd_data_b;
	logic      wr_en;
	reg_addr_t wr_addr;
	data_t     wr_data;
	decoded_t  dec;               // stage 1 register
	data_t     lane_y [NUM_LANES]; // stage 2 results

	reg_file u_reg_file (
		.clk         (clk),
		.i_rd_addr_a (rd_addr_a),
		.i_rd_addr_b (rd_addr_b),
		.o_rd_data_a (rd_data_a),
		.o_rd_data_b (rd_data_b),
		.i_wr_en     (wr_en),
		.i_wr_addr   (wr_addr),
		.i_wr_data   (wr_data)
	);

	decode_stage u_decode (
		.clk         (clk),
		.reset       (reset),
		.i_instr     (i_instr),
		.o_rd_addr_a (rd_addr_a),
		.o_rd_addr_b (rd_addr_b),
		.i_rd_data_a (rd_data_a),
		.i_rd_data_b (rd_data_b),
		.o_dec       (dec)
	);

	// ========================================================================
	// two identical lanes, each with its own b source
	// ========================================================================

	for (genvar l = 0; l < NUM_LANES; l++)
	begin : g_lane
		data_t lane_b;

		assign lane_b = (lane_e'(l) == lane_reg) ? dec.b_reg : dec.b_imm;

		alu_lane u_alu (
			.clk  (clk),
			.i_op (dec.alu_op),
			.i_a  (dec.a),
			.i_b  (lane_b),
			.o_y  (lane_y[l])
		);
	end

	commit_stage u_commit (
		.clk          (clk),
		.reset        (reset),
		.i_dec        (dec),
		.i_lane_y     (lane_y),
		.o_wr_en      (wr_en),
		.o_wr_addr    (wr_addr),
		.o_wr_data    (wr_data),
		.o_out        (o_out),
		.o_out_strobe (o_out_strobe)
	);

endmodule

//--- test/tb_pat.sv
`timescale 1ns/1ps

module tb_pat import isa_pkg::*; ();

	localparam int N_RANDOM      = 2000;
	localparam int DRAIN_TIMEOUT = 50;   // cycles allowed for the last outs

	logic        clk;
	logic        reset;
	instr_t      i_instr;
	data_t       o_out;
	logic        o_out_strobe;

	logic [31:0] lfsr;                   // random state
	int          cyc = 0;                // rising edges seen so far
	data_t       model_regs [NUM_REGS];  // architectural registers
	logic        pend_wr    [2];         // writes in flight, [0] newest
	reg_addr_t   pend_addr  [2];
	data_t       pend_data  [2];
	data_t       exp_val_q  [$];         // scoreboard, expected o_out
	int          exp_cyc_q  [$];         // edge at which each strobe is due
	data_t       chk_val;
	int          chk_cyc;

	pat_core UUT (
		.clk          (clk),
		.reset        (reset),
		.i_instr      (i_instr),
		.o_out        (o_out),
		.o_out_strobe (o_out_strobe)
	);

	always #20 clk = ~clk;   // 40 ns period

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped at cycle %0d", cyc);
	endtask

	// ========================================================================
	// stimulus helpers
	// ========================================================================

	// Galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic get_bits(input int n, output logic [7:0] v);
		v = 8'd0;
		for (int i = 0; i < n; i++)
		begin
			v    = {v[6:0], lfsr[0]};  // one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic instr_t make_instr(input reg_addr_t rn, input logic [3:0] op8,
		input imm8_t imm);
		instr_t ins;
		ins.rn  = rn;
		ins.op8 = op8;
		ins.imm = imm;
		return ins;
	endfunction

	// ========================================================================
	// reference model, write visible three slots after issue
	// ========================================================================

	task automatic model_step(input instr_t ins);
		data_t      a;
		data_t      b;
		data_t      y;
		logic [2:0] sh;
		logic [3:0] o3;
		logic       wr;
		a  = model_regs[ins.rn];
		y  = 8'd0;
		wr = 1'b0;
		o3 = ins.imm[7:4];
		if (ins.op8 != 4'hf)
		begin
			b  = ins.op8[0] ? model_regs[ins.imm[2:0]] : ins.imm; // odd -> register
			wr = (ins.op8 <= 4'd8);                                  // 9..14 do nothing
			case (ins.op8)
				4'd0, 4'd1: y = a | b;
				4'd2, 4'd3: y = a & b;
				4'd4, 4'd5: y = a + b;   // mod 256
				4'd6, 4'd7: y = a - b;
				default:    y = ins.imm; // ldi
			endcase
		end
		else if (o3 != 4'hf)
		begin
			b  = o3[0] ? model_regs[ins.imm[2:0]] : {5'd0, ins.imm[2:0]};
			sh = b[2:0];
			wr = (o3 <= 4'd7);
			case (o3)
				4'd0, 4'd1: y = a << sh;
				4'd2, 4'd3: y = (a << sh) | ~(8'hff << sh);                  // ones in
				4'd4, 4'd5: y = a >> sh;
				4'd6, 4'd7: y = (a >> sh) | (a[7] ? ~(8'hff >> sh) : 8'h00); // sign in
				4'd11:
				begin
					exp_val_q.push_back(a);        // out copies rn
					exp_cyc_q.push_back(cyc + 3);
				end
				default: ;
			endcase
		end
		else if (ins.imm[3:0] == 4'd0)
		begin
			y  = ~a;   // not
			wr = 1'b1;
		end
		// write from two slots back lands now, seen from the next slot on
		if (pend_wr[1])
			model_regs[pend_addr[1]] = pend_data[1];
		pend_wr[1]   = pend_wr[0];
		pend_addr[1] = pend_addr[0];
		pend_data[1] = pend_data[0];
		pend_wr[0]   = wr;
		pend_addr[0] = ins.rn;
		pend_data[0] = y;
	endtask

	// drive one slot, inputs change 1 ns after the edge
	task automatic issue(input instr_t ins);
		model_step(ins);
		i_instr = ins;
		@(posedge clk);
		#1;
	endtask

	task automatic random_instr(output instr_t ins);
		logic [7:0] cls;
		logic [7:0] rn;
		logic [7:0] lo;
		logic [7:0] op;
		get_bits(3, cls);
		get_bits(3, rn);
		get_bits(8, lo);
		ins = make_instr(rn[2:0], 4'hf, lo);
		case (cls[2:0])
			3'd0, 3'd1, 3'd2:
			begin
				get_bits(4, op);
				ins.op8 = op[3:0];       // includes undefined codes
			end
			3'd3, 3'd4: ;                // i3, opcode already random in imm[7:4]
			3'd5:
			begin
				ins.imm[7:4] = 4'hf;     // i0 space
				get_bits(1, op);
				if (op[0])
					ins.imm[3:0] = 4'd0; // bias towards not
			end
			3'd6:    ins.imm[7:4] = 4'd11; // out
			default: ins = INSTR_NOP;
		endcase
	endtask

	// ========================================================================
	// strobe checker, sampled mid-cycle
	// ========================================================================

	always @(negedge clk)
	begin
		if (!reset && o_out_strobe === 1'b1)
		begin
			assert (exp_val_q.size() > 0)
			else
				abort_run("output strobe seen with no out instruction pending");
			chk_val = exp_val_q.pop_front();
			chk_cyc = exp_cyc_q.pop_front();
			assert (o_out == chk_val)
			else
				abort_run($sformatf("Error: o_out = 0x%h, expected 0x%h", o_out, chk_val));
			assert (cyc == chk_cyc)
			else
				abort_run($sformatf("Error: o_out_strobe at cycle 0x%h, expected 0x%h",
					cyc, chk_cyc));
		end
	end

	// ========================================================================
	// program
	// ========================================================================

	initial
	begin
		instr_t     ins;
		logic [7:0] val;
		int         waited;
		clk     = 1'b0;
		reset   = 1'b1;
		i_instr = INSTR_NOP;
		lfsr    = 32'hb528a2c7;
		for (int i = 0; i < 2; i++)
		begin
			pend_wr[i]   = 1'b0;
			pend_addr[i] = 3'd0;
			pend_data[i] = 8'd0;
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		repeat (10) issue(INSTR_NOP);  // idle pipe, strobe must stay low
		for (int r = 0; r < NUM_REGS; r++)
		begin
			get_bits(8, val);
			issue(make_instr(reg_addr_t'(r), 4'd8, val)); // ldi every register
		end
		repeat (2) issue(INSTR_NOP);

		// ldi then out three slots later
		issue(make_instr(3'd3, 4'd8, 8'hc3));
		repeat (2) issue(INSTR_NOP);
		issue(make_instr(3'd3, 4'hf, 8'hbf));
		// readers at one, two and three slots behind a write
		issue(make_instr(3'd2, 4'd8, 8'h5a));
		repeat (3) issue(make_instr(3'd2, 4'hf, 8'hbf));

		for (int i = 0; i < N_RANDOM; i++)
		begin
			random_instr(ins);
			issue(ins);
		end

		waited = 0;
		while (exp_val_q.size() != 0 && waited < DRAIN_TIMEOUT)
		begin
			issue(INSTR_NOP);
			waited++;
		end
		if (exp_val_q.size() != 0)
			abort_run("timed out waiting for the last out strobes");
		else
		begin
			repeat (8) issue(INSTR_NOP); // no stray strobe after the last out
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

//--- vlog.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/reg_file.sv
src/decode_stage.sv
src/alu_lane.sv
src/commit_stage.sv
src/pat_core.sv
test/tb_pat.sv

//--- Makefile
# Verilator build, run, lint and clean for the pat_core testbench

VERILATOR  ?= verilator
TOP        ?= tb_pat
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# a $fatal in the testbench makes the binary exit non-zero
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
